// File: hdl/vec_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the SIMT vector block.
// Lane count is not defined here. Lane buses and enables are sized by the
// NUM_LANES module parameter, set at the top level.
// Command word layout is fixed at 16 bits with 3 spare bits at the bottom.
////////////////////////////////////////////////////////////////////////////

package vec_pkg;

	localparam int DATA_W     = 16;				// Lane word width
	localparam int NUM_REGS   = 4;				// Registers per lane
	localparam int REG_IDX_W  = $clog2(NUM_REGS);
	localparam int LANE_SEL_W = 4;				// Raw lane select field
	localparam int TID_W      = 8;

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [REG_IDX_W-1:0]  reg_idx_t;
	typedef logic [LANE_SEL_W-1:0] lane_sel_t;
	typedef logic [TID_W-1:0]      thread_id_t;

	////////////////////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,	// dst = src1 + src2
		OP_SUB   = 3'd1,	// dst = src1 - src2
		OP_AND   = 3'd2,	// dst = src1 & src2
		OP_XOR   = 3'd3,	// dst = src1 ^ src2
		OP_BCAST = 3'd4,	// dst = scalar input
		OP_TID   = 3'd5,	// dst = thread id + lane index
		OP_ROT   = 3'd6,	// dst = src1 of next lane up
		OP_RDS   = 3'd7		// Scalar readout, no write
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Command formats
	////////////////////////////////////////////////////////////////////////////

	// Raw command word, MSB first
	typedef struct packed {
		opcode_t   opcode;		// [15:13]
		reg_idx_t  dst;			// [12:11]
		reg_idx_t  src1;		// [10:9]
		reg_idx_t  src2;		// [8:7]
		lane_sel_t lane_sel;	// [6:3]
		logic [2:0] spare;		// Ignored
	} cmd_word_t;

	// Decoded command as seen by every lane
	typedef struct packed {
		logic      issue;		// One-cycle issue pulse
		opcode_t   opcode;
		reg_idx_t  dst;
		reg_idx_t  src1;
		reg_idx_t  src2;
		lane_sel_t lane_sel;	// Already wrapped to a valid lane
	} lane_cmd_t;

endpackage

// File: hdl/cmd_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Command decoder.
// Registers a strobed command word into the lane command struct, so the
// issue bit is high for exactly one cycle after an accepted strobe.
// Strobes that arrive while busy is high are dropped, not queued.
// lane_sel is wrapped modulo NUM_LANES; the spare bits are ignored.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cmd_decoder #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 cmd_valid,		// Single-cycle strobe
	input  vec_pkg::cmd_word_t   cmd,
	input  logic                 busy,			// Commit still pending
	output vec_pkg::lane_cmd_t   lane_cmd
);

	import vec_pkg::*;

	logic      accept;
	lane_sel_t lane_sel_wrap;
	lane_cmd_t cmd_q;

	assign accept = cmd_valid & ~busy;		// Drop while busy

	// Keep later stages inside the lane range
	assign lane_sel_wrap = lane_sel_t'(cmd.lane_sel % NUM_LANES);

	////////////////////////////////////////////////////////////////////////////
	// Command register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q.issue    <= 1'b0;
			cmd_q.opcode   <= OP_ADD;
			cmd_q.dst      <= '0;
			cmd_q.src1     <= '0;
			cmd_q.src2     <= '0;
			cmd_q.lane_sel <= '0;
		end else begin
			cmd_q.issue <= accept;			// One-cycle pulse
			if (accept) begin
				cmd_q.opcode   <= cmd.opcode;
				cmd_q.dst      <= cmd.dst;
				cmd_q.src1     <= cmd.src1;
				cmd_q.src2     <= cmd.src2;
				cmd_q.lane_sel <= lane_sel_wrap;
			end
		end
	end

	assign lane_cmd = cmd_q;

endmodule

// File: hdl/lane_alu.sv
////////////////////////////////////////////////////////////////////////////
// Operation unit of one lane, purely combinational.
// Arithmetic wraps at the word width. No flags are produced.
// writes is low only for OP_RDS, which reads a register out and
// leaves the register file alone.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_alu (
	input  vec_pkg::opcode_t opcode,
	input  vec_pkg::data_t   src1,
	input  vec_pkg::data_t   src2,
	input  vec_pkg::data_t   scalar_in,
	input  vec_pkg::data_t   neighbour_src1,	// src1 of lane (i+1) mod N
	input  vec_pkg::data_t   tid_sum,			// Thread id plus lane index
	output vec_pkg::data_t   result,
	output logic             writes
);

	import vec_pkg::*;

	always_comb begin
		unique case (opcode)
			OP_ADD:   result = src1 + src2;
			OP_SUB:   result = src1 - src2;
			OP_AND:   result = src1 & src2;
			OP_XOR:   result = src1 ^ src2;
			OP_BCAST: result = scalar_in;
			OP_TID:   result = tid_sum;
			OP_ROT:   result = neighbour_src1;
			OP_RDS:   result = src1;			// Not written back
			default:  result = '0;
		endcase
	end

	// Every operation except readout writes a register
	assign writes = (opcode != OP_RDS);

endmodule

// File: hdl/lane_unit.sv
////////////////////////////////////////////////////////////////////////////
// One SIMT lane: four-word register file, ALU, commit flag.
// A disabled lane ignores issues for writing operations and never commits.
// OP_RDS captures src1 into scalar_value in every lane; the vector unit
// picks the lane. The commit flag holds until commit_grant clears it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_unit #(
	parameter int NUM_LANES = 4,
	parameter int LANE_ID   = 0
) (
	input  logic                                clock,
	input  logic                                rst_n,
	input  vec_pkg::lane_cmd_t                  lane_cmd,
	input  logic                                en_lane,		// Lane takes part
	input  logic                                commit_grant,	// Clears commit
	input  vec_pkg::thread_id_t                 thread_id,
	input  vec_pkg::data_t                      scalar_in,
	input  vec_pkg::data_t [NUM_LANES-1:0]      lane_src1_bus,	// All lanes' src1
	output vec_pkg::data_t                      lane_src1,
	output vec_pkg::data_t                      lane_wb,
	output vec_pkg::data_t                      scalar_value,
	output logic                                commit
);

	import vec_pkg::*;

	localparam int NBR_ID = (LANE_ID + 1) % NUM_LANES;	// Rotate source lane

	data_t regs [NUM_REGS];
	data_t src1_val;
	data_t src2_val;
	data_t tid_sum;
	data_t alu_result;
	logic  alu_writes;
	logic  wr_en;
	logic  rds_issue;

	assign src1_val = regs[lane_cmd.src1];
	assign src2_val = regs[lane_cmd.src2];
	assign tid_sum  = data_t'(thread_id) + data_t'(LANE_ID);

	lane_alu lane_alu_i (
		.opcode         (lane_cmd.opcode),
		.src1           (src1_val),
		.src2           (src2_val),
		.scalar_in      (scalar_in),
		.neighbour_src1 (lane_src1_bus[NBR_ID]),
		.tid_sum        (tid_sum),
		.result         (alu_result),
		.writes         (alu_writes)
	);

	assign wr_en     = lane_cmd.issue & en_lane & alu_writes;
	assign rds_issue = lane_cmd.issue & (lane_cmd.opcode == OP_RDS);

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else if (wr_en) begin
			regs[lane_cmd.dst] <= alu_result;
		end
	end

	// Scalar readout capture
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			scalar_value <= '0;
		end else if (rds_issue) begin
			scalar_value <= src1_val;		// Held until next OP_RDS
		end
	end

	// Commit flag, a new write wins over a grant
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			commit <= 1'b0;
		end else if (wr_en) begin
			commit <= 1'b1;
		end else if (commit_grant) begin
			commit <= 1'b0;
		end
	end

	// Lane bus slots
	assign lane_src1 = src1_val;
	assign lane_wb   = alu_result;

endmodule

// File: hdl/vector_unit.sv
////////////////////////////////////////////////////////////////////////////
// Vector unit with NUM_LANES identical lanes on shared lane buses.
// commit_req needs every enabled lane committed and at least one lane
// enabled; it follows the flags combinationally.
// scalar_out is taken from the lane named at the last OP_RDS issue.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vector_unit #(
	parameter int NUM_LANES = 4
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  vec_pkg::lane_cmd_t    lane_cmd,
	input  logic [NUM_LANES-1:0]  en_lane,
	input  logic [NUM_LANES-1:0]  commit_grant,
	input  vec_pkg::thread_id_t   thread_id,
	input  vec_pkg::data_t        scalar_in,
	output vec_pkg::data_t        scalar_out,
	output logic                  commit_req,		// Level
	output logic [NUM_LANES-1:0]  status,			// Per-lane commit flags
	output logic                  busy
);

	import vec_pkg::*;

	localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	data_t [NUM_LANES-1:0] lane_src1_bus;
	data_t [NUM_LANES-1:0] scalar_vals;
	logic  [NUM_LANES-1:0] commit;
	logic  [SEL_W-1:0]     rds_sel;

	////////////////////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++) begin : lane_g
		lane_unit #(
			.NUM_LANES (NUM_LANES),
			.LANE_ID   (i)
		) lane_unit_i (
			.clock         (clock),
			.rst_n         (rst_n),
			.lane_cmd      (lane_cmd),
			.en_lane       (en_lane[i]),
			.commit_grant  (commit_grant[i]),
			.thread_id     (thread_id),
			.scalar_in     (scalar_in),
			.lane_src1_bus (lane_src1_bus),
			.lane_src1     (lane_src1_bus[i]),
			.lane_wb       (),
			.scalar_value  (scalar_vals[i]),
			.commit        (commit[i])
		);
	end

	// Lane choice for readout, latched with the OP_RDS issue
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rds_sel <= '0;
		end else if (lane_cmd.issue && lane_cmd.opcode == OP_RDS) begin
			rds_sel <= lane_cmd.lane_sel[SEL_W-1:0];
		end
	end

	assign scalar_out = scalar_vals[rds_sel];

	assign commit_req = (|en_lane) && ((commit & en_lane) == en_lane);
	assign busy       = |commit;
	assign status     = commit;

endmodule

// File: hdl/vec_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the SIMT vector block, decoder plus vector unit.
// Commands are accepted only while busy is low; a strobe during busy is
// lost. Hold commit_grant for the enabled lanes to release busy.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_top #(
	parameter int NUM_LANES = 4
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  cmd_valid,		// Command strobe
	input  vec_pkg::cmd_word_t    cmd,
	input  logic [NUM_LANES-1:0]  en_lane,
	input  logic [NUM_LANES-1:0]  commit_grant,
	input  vec_pkg::thread_id_t   thread_id,
	input  vec_pkg::data_t        scalar_in,
	output vec_pkg::data_t        scalar_out,
	output logic                  commit_req,
	output logic [NUM_LANES-1:0]  status,
	output logic                  busy
);

	import vec_pkg::*;

	lane_cmd_t lane_cmd;		// Decoded command to all lanes

	cmd_decoder #(
		.NUM_LANES (NUM_LANES)
	) cmd_decoder_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.lane_cmd  (lane_cmd)
	);

	vector_unit #(
		.NUM_LANES (NUM_LANES)
	) vector_unit_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.lane_cmd     (lane_cmd),
		.en_lane      (en_lane),
		.commit_grant (commit_grant),
		.thread_id    (thread_id),
		.scalar_in    (scalar_in),
		.scalar_out   (scalar_out),
		.commit_req   (commit_req),
		.status       (status),
		.busy         (busy)
	);

endmodule

// File: sim/tb_vec_top.sv
////////////////////////////////////////////////////////////////////////////
// Table-driven testbench for the SIMT vector block with four lanes.
// Rows are applied one at a time. Every write is followed by a grant to
// all lanes, except a held write that leaves busy high for a drop test.
// Scalar readout is sampled two cycles after the strobe, on a falling edge.
// Expected register contents come from a 4x4 reference image.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vec_top;

	import vec_pkg::*;

	localparam int NL          = 4;
	localparam int TIMEOUT_CYC = 20;

	typedef enum {CK_WRITE, CK_HOLD, CK_DROP, CK_READ} check_t;

	typedef struct {
		string      name;
		cmd_word_t  cmd;
		logic [NL-1:0] en;
		data_t      scalar;
		thread_id_t tid;
		check_t     kind;
		logic [NL-1:0] exp_status;	// Flags expected after a write or drop
	} row_t;

	logic          clock;
	logic          rst_n;
	logic          cmd_valid;
	cmd_word_t     cmd;
	logic [NL-1:0] en_lane;
	logic [NL-1:0] commit_grant;
	thread_id_t    thread_id;
	data_t         scalar_in;
	data_t         scalar_out;
	logic          commit_req;
	logic [NL-1:0] status;
	logic          busy;

	row_t        rows[$];
	data_t       model [NL][NUM_REGS];	// Reference register image
	logic [31:0] rng_state;
	int          errors;
	int          n_pass;
	int          n_fail;

	vec_top #(
		.NUM_LANES (NL)
	) vec_top_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.en_lane      (en_lane),
		.commit_grant (commit_grant),
		.thread_id    (thread_id),
		.scalar_in    (scalar_in),
		.scalar_out   (scalar_out),
		.commit_req   (commit_req),
		.status       (status),
		.busy         (busy)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic data_t next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state[DATA_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_lanes(input string name, input logic [NL-1:0] exp,
			input logic [NL-1:0] act);
		if (act !== exp) begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Table
	////////////////////////////////////////////////////////////////////////////
	task automatic add_row(input string name, input opcode_t op, input int dst,
			input int src1, input int src2, input int sel, input logic [NL-1:0] en,
			input data_t scalar, input thread_id_t tid, input check_t kind);
		row_t r;
		r.name         = name;
		r.cmd.opcode   = op;
		r.cmd.dst      = reg_idx_t'(dst);
		r.cmd.src1     = reg_idx_t'(src1);
		r.cmd.src2     = reg_idx_t'(src2);
		r.cmd.lane_sel = lane_sel_t'(sel);
		r.cmd.spare    = 3'b101;		// Must be ignored
		r.en           = en;
		r.scalar       = scalar;
		r.tid          = tid;
		r.kind         = kind;
		r.exp_status   = en;
		rows.push_back(r);
	endtask

	task automatic add_reads(input string tag, input int src1);
		for (int l = 0; l < NL; l++) begin
			add_row($sformatf("%s_l%0d", tag, l), OP_RDS, 0, src1, 0, l, '1, '0, '0, CK_READ);
		end
	endtask

	task automatic build_table();
		for (int r = 0; r < NUM_REGS; r++) begin	// Random value per register
			add_row($sformatf("bcast_r%0d", r), OP_BCAST, r, 0, 0, 0, '1, next_rand(), '0,
				CK_WRITE);
		end
		for (int l = 0; l < NL; l++) begin
			add_row($sformatf("bcast_rd_l%0d", l), OP_RDS, 0, l, 0, l, '1, '0, '0, CK_READ);
		end
		add_row("tid_r0", OP_TID, 0, 0, 0, 0, '1, '0, 8'hc3, CK_WRITE);
		add_row("add_r1", OP_ADD, 1, 0, 2, 0, '1, '0, '0, CK_WRITE);
		add_row("sub_r2", OP_SUB, 2, 1, 3, 0, '1, '0, '0, CK_WRITE);
		add_row("and_r3", OP_AND, 3, 2, 1, 0, '1, '0, '0, CK_WRITE);
		add_row("xor_r0", OP_XOR, 0, 3, 1, 0, '1, '0, '0, CK_WRITE);
		add_reads("alu_r0", 0);
		add_reads("alu_r2", 2);
		add_row("rds_wrap_sel6", OP_RDS, 0, 2, 0, 6, '1, '0, '0, CK_READ);	// r2 differs per lane
		add_row("rot_r2", OP_ROT, 2, 0, 0, 0, '1, '0, '0, CK_WRITE);
		add_reads("rot_r2", 2);
		add_row("partial_r3", OP_BCAST, 3, 0, 0, 0, 4'b0101, next_rand(), '0, CK_WRITE);
		add_reads("partial_r3", 3);
		add_row("hold_r1", OP_BCAST, 1, 0, 0, 0, '1, next_rand(), '0, CK_HOLD);
		add_row("drop_r1", OP_BCAST, 1, 0, 0, 0, '1, next_rand(), '0, CK_DROP);
		add_reads("drop_r1", 1);
	endtask

	// Opcode rules on a snapshot, so a rotate reads old neighbour values
	task automatic update_model(input row_t r);
		data_t nxt [NL][NUM_REGS];
		nxt = model;
		for (int l = 0; l < NL; l++) begin
			if (r.en[l]) begin
				case (r.cmd.opcode)
					OP_ADD:   nxt[l][r.cmd.dst] = model[l][r.cmd.src1] + model[l][r.cmd.src2];
					OP_SUB:   nxt[l][r.cmd.dst] = model[l][r.cmd.src1] - model[l][r.cmd.src2];
					OP_AND:   nxt[l][r.cmd.dst] = model[l][r.cmd.src1] & model[l][r.cmd.src2];
					OP_XOR:   nxt[l][r.cmd.dst] = model[l][r.cmd.src1] ^ model[l][r.cmd.src2];
					OP_BCAST: nxt[l][r.cmd.dst] = r.scalar;
					OP_TID:   nxt[l][r.cmd.dst] = data_t'(r.tid) + data_t'(l);
					OP_ROT:   nxt[l][r.cmd.dst] = model[(l + 1) % NL][r.cmd.src1];
					default:  ;		// Readout leaves registers alone
				endcase
			end
		end
		model = nxt;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus actions
	////////////////////////////////////////////////////////////////////////////
	task automatic issue_cmd(input row_t r);
		@(posedge clock);
		cmd_valid <= 1'b1;
		cmd       <= r.cmd;
		en_lane   <= r.en;
		scalar_in <= r.scalar;
		thread_id <= r.tid;
		@(posedge clock);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_commit(input string name);
		int cnt;
		cnt = 0;
		@(negedge clock);
		while (!commit_req && cnt < TIMEOUT_CYC) begin
			@(negedge clock);
			cnt++;
		end
		if (!commit_req) begin
			$display("%s: commit_req never rose after the command", name);
			errors++;
		end
	endtask

	task automatic grant_all(input string name);
		int cnt;
		cnt = 0;
		@(posedge clock);
		commit_grant <= '1;
		@(negedge clock);
		while (busy && cnt < TIMEOUT_CYC) begin
			@(negedge clock);
			cnt++;
		end
		if (busy) begin
			$display("%s: busy stayed high while all lanes were granted", name);
			errors++;
		end else if (commit_req) begin
			$display("%s: commit_req still high after the grant", name);
			errors++;
		end
		check_lanes(name, '0, status);		// All flags cleared
		@(posedge clock);
		commit_grant <= '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int err_before;
		rst_n        <= 1'b0;
		cmd_valid    <= 1'b0;
		cmd          <= '0;
		en_lane      <= '0;
		commit_grant <= '0;
		thread_id    <= '0;
		scalar_in    <= '0;
		errors    = 0;
		n_pass    = 0;
		n_fail    = 0;
		rng_state = 32'd79667;
		for (int l = 0; l < NL; l++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				model[l][r] = '0;
			end
		end
		build_table();
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;

		foreach (rows[i]) begin
			err_before = errors;
			case (rows[i].kind)
				CK_WRITE, CK_HOLD: begin
					issue_cmd(rows[i]);
					wait_commit(rows[i].name);
					check_lanes(rows[i].name, rows[i].exp_status, status);
					update_model(rows[i]);
					if (rows[i].kind == CK_WRITE) begin
						grant_all(rows[i].name);
					end
				end
				CK_DROP: begin
					if (!busy) begin
						$display("%s: busy was low before the strobe to drop", rows[i].name);
						errors++;
					end
					issue_cmd(rows[i]);
					@(posedge clock);
					@(negedge clock);
					check_lanes(rows[i].name, rows[i].exp_status, status);
					grant_all(rows[i].name);
				end
				default: begin		// Readout, valid two cycles after strobe
					issue_cmd(rows[i]);
					@(posedge clock);
					@(negedge clock);
					check_data(rows[i].name,
						model[rows[i].cmd.lane_sel % NL][rows[i].cmd.src1], scalar_out);
				end
			endcase
			if (errors == err_before) begin
				n_pass++;
				$display("test %s passed", rows[i].name);
			end else begin
				n_fail++;
				$display("test %s failed", rows[i].name);
			end
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			rows.size(), n_pass, n_fail, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
hdl/vec_pkg.sv
hdl/cmd_decoder.sv
hdl/lane_alu.sv
hdl/lane_unit.sv
hdl/vector_unit.sv
hdl/vec_top.sv
sim/tb_vec_top.sv

// File: Bender.yml
package:
  name: vec_simt

sources:
  - hdl/vec_pkg.sv
  - hdl/cmd_decoder.sv
  - hdl/lane_alu.sv
  - hdl/lane_unit.sv
  - hdl/vector_unit.sv
  - hdl/vec_top.sv
  - target: simulation
    files:
      - sim/tb_vec_top.sv
